//--- files.f
dcache_pkg.sv
dcache_lookup.sv
dcache_fill.sv
dcache_data.sv
dcache_bus_ctrl.sv
dcache_top.sv
dcache_checker.sv
tb_dcache.sv

//--- run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_dcache -f files.f

out=$(./obj_dir/Vtb_dcache)
printf '%s\n' "$out"

# The run passes only if the testbench printed its pass line.
printf '%s\n' "$out" | grep -q -x -F '>>> PASS'

//--- tb_dcache.sv
// Data cache testbench
module tb_dcache;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] window_base = 32'h0004_3000;	// 4 KiB, four lines per index.
	localparam int          num_tests   = 400;
	localparam int          wait_limit  = 200;

	logic        clk;
	logic        rst_n;
	logic [31:0] addr;
	logic        rd_req;
	logic        wr_req;
	logic [31:0] wr_data;
	logic        rw_wait;
	logic [31:0] rd_data;
	logic        bus_req;
	logic        bus_ack;
	logic [31:0] bus_addr;
	logic [31:0] bus_rdata;
	logic [31:0] bus_wdata;
	logic        bus_rd;
	logic        bus_wr;
	logic        bus_ready;

	logic [31:0] slave_mem [1024];
	logic        timed_out;

	dcache_top u_dcache_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.addr      (addr),
		.rd_req    (rd_req),
		.wr_req    (wr_req),
		.wr_data   (wr_data),
		.rw_wait   (rw_wait),
		.rd_data   (rd_data),
		.bus_req   (bus_req),
		.bus_ack   (bus_ack),
		.bus_addr  (bus_addr),
		.bus_rdata (bus_rdata),
		.bus_wdata (bus_wdata),
		.bus_rd    (bus_rd),
		.bus_wr    (bus_wr),
		.bus_ready (bus_ready)
	);

	dcache_checker u_checker (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Bus slave
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] fill_pattern(input logic [31:0] a);
		return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
	endfunction

	initial begin
		for (int i = 0; i < 1024; i++) begin
			slave_mem[i] <= fill_pattern(window_base | (32'(i) << 2));
		end
	end

	assign bus_rdata = slave_mem[bus_addr[11:2]];	// Asynchronous memory read port.

	always @(posedge clk) begin
		if (bus_wr && bus_ack && bus_ready) begin
			slave_mem[bus_addr[11:2]] <= bus_wdata;
		end
	end

	////////////////////////////////////////////////////////////
	// Core stimulus
	////////////////////////////////////////////////////////////

	// Grant and ready are high on about three cycles in four.
	task automatic next_cycle();
		@(negedge clk);
		bus_ack   = ($urandom_range(0, 3) != 0);
		bus_ready = ($urandom_range(0, 3) != 0);
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (2) next_cycle();
		rst_n = 1'b1;
	endtask

	// Half the requests stay in the previous line so that hits are common.
	function automatic logic [31:0] pick_addr(input logic [31:0] prev);
		logic [9:0] w;
		if ($urandom_range(0, 1) == 0) begin
			w = {prev[11:6], 4'($urandom_range(0, 15))};
		end else begin
			w = 10'($urandom_range(0, 1023));
		end
		return window_base | {20'b0, w, 2'b00};
	endfunction

	task automatic do_request(input logic is_write, input logic [31:0] a, output logic late);
		int   n;
		logic done;
		n       = 0;
		done    = 1'b0;
		late    = 1'b0;
		addr    = a;
		rd_req  = !is_write;
		wr_req  = is_write;
		wr_data = $urandom;
		while (!done && !late) begin
			@(posedge clk);
			done = !rw_wait;
			n++;
			if (!done && n >= wait_limit) begin
				late = 1'b1;
			end
			next_cycle();
		end
		rd_req = 1'b0;
		wr_req = 1'b0;
	endtask

	initial begin
		logic [31:0] a;
		void'($urandom(27));
		a         = window_base;
		timed_out = 1'b0;
		rst_n     = 1'b0;
		addr      = '0;
		rd_req    = 1'b0;
		wr_req    = 1'b0;
		wr_data   = '0;
		bus_ack   = 1'b0;
		bus_ready = 1'b0;
		apply_reset();
		for (int i = 0; i < num_tests && !timed_out; i++) begin
			if (i == num_tests / 2) begin
				apply_reset();	// Every line must miss again after this.
			end
			if ($urandom_range(0, 7) == 0) begin
				next_cycle();
			end
			a = pick_addr(a);
			do_request($urandom_range(0, 2) == 0, a, timed_out);
		end
		if (timed_out) begin
			$display("timeout: rw_wait stayed high for %0d cycles on address 0x%08h", wait_limit, a);
		end
		$display("tests %0d, errors %0d", u_checker.tests, u_checker.errors);
		if (!timed_out && u_checker.errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- dcache_checker.sv
// Cache response checker
// Reference cache and memory model.
module dcache_checker (
	input logic        clk,
	input logic        rst_n,
	input logic [31:0] addr,
	input logic        rd_req,
	input logic        wr_req,
	input logic [31:0] wr_data,
	input logic        rw_wait,
	input logic [31:0] rd_data,
	input logic        bus_req,
	input logic        bus_ack,
	input logic [31:0] bus_addr,
	input logic [31:0] bus_wdata,
	input logic        bus_rd,
	input logic        bus_wr,
	input logic        bus_ready
);
	timeunit 1ns;
	timeprecision 1ps;

	int tests = 0;
	int errors = 0;

	logic [31:0] model_mem [logic [31:0]];	// Only words written so far.
	logic [15:0] model_valid;
	logic [21:0] model_tag [16];

	int          cycles;	// Cycles the current request has waited.
	int          beats;
	int          writes;
	int          test_errors;
	logic [3:0]  idx;
	logic [21:0] tag;
	logic        expect_hit;
	logic [31:0] expected;

	// Same address mix as the bus slave uses for its initial contents.
	function automatic logic [31:0] initial_word(input logic [31:0] a);
		return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
	endfunction

	function automatic logic [31:0] model_word(input logic [31:0] a);
		if (model_mem.exists(a)) begin
			return model_mem[a];
		end
		return initial_word(a);
	endfunction

	task automatic report_mismatch(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		errors++;
		test_errors++;
	endtask

	task automatic report_failure(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		errors++;
		test_errors++;
	endtask

	////////////////////////////////////////////////////////////
	// Request completion
	////////////////////////////////////////////////////////////

	task automatic finish_request();
		string kind;
		expect_hit = model_valid[idx] && (model_tag[idx] == tag);
		if (rd_req) begin
			expected = model_word(addr);
			if (rd_data !== expected) begin
				report_mismatch($sformatf("read 0x%08h returned 0x%08h, expected 0x%08h",
					addr, rd_data, expected));
			end
			if (expect_hit && (cycles != 0 || beats != 0)) begin
				report_mismatch($sformatf("read hit 0x%08h waited %0d cycles", addr, cycles));
			end
			if (!expect_hit && beats != 16) begin
				report_mismatch($sformatf("read miss 0x%08h made %0d bus reads, expected 16",
					addr, beats));
			end
			model_valid[idx] = 1'b1;	// The fill replaces whatever line sat here.
			model_tag[idx]   = tag;
			kind = expect_hit ? "read hit" : "read fill";
		end else begin
			if (writes != 1 || beats != 0) begin
				report_mismatch($sformatf("write 0x%08h made %0d bus writes and %0d bus reads",
					addr, writes, beats));
			end
			model_mem[addr] = wr_data;	// No allocation on a write miss.
			kind = expect_hit ? "write hit" : "write miss";
		end
		tests++;
		$display("test %0d %s 0x%08h %s", tests, kind, addr,
			(test_errors == 0) ? "ok" : "failed");
	endtask

	////////////////////////////////////////////////////////////
	// Cycle monitor
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!rst_n) begin
			model_valid = '0;
			cycles      = 0;
			beats       = 0;
			writes      = 0;
			test_errors = 0;
		end else begin
			idx = addr[9:6];
			tag = addr[31:10];
			if ((bus_rd || bus_wr) && !bus_ack) begin
				report_failure("bus strobe is high without a grant");
			end
			if (bus_rd && !rd_req) begin
				report_failure("bus read issued while the core is not reading");
			end
			if (wr_req && !bus_req) begin
				report_failure("no bus request during a core write");
			end
			if (rd_req && (bus_req !== rw_wait)) begin
				report_failure("bus request does not follow the read miss");
			end
			if (bus_rd && bus_ack && bus_ready) begin
				if (beats >= 16) begin
					report_failure("more than 16 bus reads for one line fill");
				end else if (bus_addr !== {addr[31:6], 4'(beats), 2'b00}) begin
					report_mismatch($sformatf("fill read %0d went to 0x%08h", beats, bus_addr));
				end
				beats++;
			end
			if (bus_wr && bus_ack && bus_ready) begin
				if (!wr_req || rw_wait) begin
					report_failure("bus write outside a completing core write");
				end else if (bus_addr !== addr || bus_wdata !== wr_data) begin
					report_mismatch($sformatf(
						"bus write 0x%08h <= 0x%08h, expected 0x%08h <= 0x%08h",
						bus_addr, bus_wdata, addr, wr_data));
				end
				writes++;
			end
			if (!rd_req && !wr_req) begin
				if (rw_wait || bus_req) begin
					report_failure("wait or bus request raised with no core request");
				end
				cycles      = 0;
				beats       = 0;
				writes      = 0;
				test_errors = 0;
			end else if (!rw_wait) begin
				finish_request();
				cycles      = 0;
				beats       = 0;
				writes      = 0;
				test_errors = 0;
			end else begin
				cycles++;
			end
		end
	end

endmodule

//--- dcache_top.sv
// Direct-mapped write-through data cache
module dcache_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] addr,
	input  logic        rd_req,
	input  logic        wr_req,
	input  logic [31:0] wr_data,
	output logic        rw_wait,
	output logic [31:0] rd_data,
	output logic        bus_req,
	input  logic        bus_ack,
	output logic [31:0] bus_addr,
	input  logic [31:0] bus_rdata,
	output logic [31:0] bus_wdata,
	output logic        bus_rd,
	output logic        bus_wr,
	input  logic        bus_ready
);

	dcache_pkg::core_req_t             req;
	dcache_pkg::lookup_t               lookup;
	dcache_pkg::fill_wr_t              fill_wr;
	dcache_pkg::bus_cmd_t              bus_cmd;
	logic [dcache_pkg::word_width-1:0] fill_word;
	logic                              line_done;
	logic                              write_done;

	assign req.addr  = addr;
	assign req.rd    = rd_req;
	assign req.wr    = wr_req;
	assign req.wdata = wr_data;

	////////////////////////////////////////////////////////////
	// Stage chain
	////////////////////////////////////////////////////////////

	dcache_lookup u_lookup (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.line_done (line_done),
		.lookup    (lookup)
	);

	dcache_fill u_fill (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.lookup    (lookup),
		.bus_ack   (bus_ack),
		.bus_ready (bus_ready),
		.bus_rdata (bus_rdata),
		.fill_word (fill_word),
		.fill_wr   (fill_wr),
		.line_done (line_done)
	);

	dcache_data u_data (
		.clk        (clk),
		.req        (req),
		.lookup     (lookup),
		.fill_wr    (fill_wr),
		.write_done (write_done),
		.rd_data    (rd_data)
	);

	dcache_bus_ctrl u_bus_ctrl (
		.req        (req),
		.lookup     (lookup),
		.fill_word  (fill_word),
		.bus_ack    (bus_ack),
		.bus_ready  (bus_ready),
		.bus_req    (bus_req),
		.bus_cmd    (bus_cmd),
		.rw_wait    (rw_wait),
		.write_done (write_done)
	);

	// Strobes come straight from the opcode.
	assign bus_addr  = bus_cmd.addr;
	assign bus_wdata = bus_cmd.wdata;
	assign bus_rd    = (bus_cmd.op == dcache_pkg::BUS_READ);
	assign bus_wr    = (bus_cmd.op == dcache_pkg::BUS_WRITE);

endmodule

//--- dcache_bus_ctrl.sv
// Bus control
// Bus opcode, address and core wait level.
module dcache_bus_ctrl (
	input  dcache_pkg::core_req_t             req,
	input  dcache_pkg::lookup_t               lookup,
	input  logic [dcache_pkg::word_width-1:0] fill_word,
	input  logic                              bus_ack,
	input  logic                              bus_ready,
	output logic                              bus_req,
	output dcache_pkg::bus_cmd_t              bus_cmd,
	output logic                              rw_wait,
	output logic                              write_done
);

	logic read_miss;

	assign read_miss = req.rd && !lookup.hit;

	// Every write goes out, reads only when they miss.
	assign bus_req = read_miss || req.wr;

	assign write_done = req.wr && bus_ack && bus_ready;

	// A read waits for the fill, a write for its bus beat.
	assign rw_wait = read_miss || (req.wr && !write_done);

	////////////////////////////////////////////////////////////
	// Bus command
	////////////////////////////////////////////////////////////

	always_comb begin
		bus_cmd.op    = dcache_pkg::BUS_IDLE;
		bus_cmd.addr  = '0;
		bus_cmd.wdata = '0;
		if (read_miss && bus_ack) begin
			bus_cmd.op   = dcache_pkg::BUS_READ;
			// Word reads walk the line from word 0.
			bus_cmd.addr = {lookup.fields.tag, lookup.fields.index, fill_word, 2'b00};
		end else if (req.wr && bus_ack) begin
			bus_cmd.op    = dcache_pkg::BUS_WRITE;
			bus_cmd.addr  = req.addr;
			bus_cmd.wdata = req.wdata;
		end
	end

	// A fill read while the core writes would mean both requests are up.
	always_comb begin
		a_no_read_on_write: assert (!(bus_cmd.op == dcache_pkg::BUS_READ && req.wr))
		else $error("bus read issued during a write request");
	end

endmodule

//--- dcache_data.sv
// Cache data array
module dcache_data (
	input  logic                  clk,
	input  dcache_pkg::core_req_t req,
	input  dcache_pkg::lookup_t   lookup,
	input  dcache_pkg::fill_wr_t  fill_wr,
	input  logic                  write_done,
	output logic [31:0]           rd_data
);

	// Contents mean nothing until the line's valid bit is set.
	logic [31:0] mem [dcache_pkg::line_count][dcache_pkg::words_per_line];

	logic write_hit;

	// Write-through: a hit updates the copy when the bus write completes.
	assign write_hit = req.wr && lookup.hit && write_done;

	////////////////////////////////////////////////////////////
	// Write ports
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (fill_wr.en) begin
			mem[fill_wr.index][fill_wr.word] <= fill_wr.data;
		end else if (write_hit) begin
			mem[lookup.fields.index][lookup.fields.word] <= req.wdata;
		end
	end

	////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////

	// Asynchronous read gives data in the cycle of a hit.
	assign rd_data = mem[lookup.fields.index][lookup.fields.word];

endmodule

//--- dcache_fill.sv
// Line fill sequencer
module dcache_fill (
	input  logic                              clk,
	input  logic                              rst_n,
	input  dcache_pkg::core_req_t             req,
	input  dcache_pkg::lookup_t               lookup,
	input  logic                              bus_ack,
	input  logic                              bus_ready,
	input  logic [31:0]                       bus_rdata,
	output logic [dcache_pkg::word_width-1:0] fill_word,
	output dcache_pkg::fill_wr_t              fill_wr,
	output logic                              line_done
);

	localparam int line_bits = dcache_pkg::tag_width + dcache_pkg::index_width;

	dcache_pkg::fill_state_e state;

	logic [dcache_pkg::word_width-1:0] word_cnt;
	logic [line_bits-1:0]              fill_line;	// Line being filled.
	logic [line_bits-1:0]              cur_line;
	logic                              restart;
	logic                              beat;

	assign cur_line = {lookup.fields.tag, lookup.fields.index};

	// A running fill is dropped when the core moves to another line or the
	// line hits. A write breaks it too, since the filled words would go stale.
	assign restart = (state == dcache_pkg::FILL_RUN) && (req.rd || req.wr) &&
		((cur_line != fill_line) || lookup.hit || req.wr);

	// A dropped fill starts over at word 0 in this very cycle.
	assign fill_word = restart ? '0 : word_cnt;

	// One completed read beat of a missing read.
	assign beat = req.rd && !lookup.hit && bus_ack && bus_ready;

	assign line_done = beat && (&fill_word);	// Word 15 arrived.

	assign fill_wr.en    = beat;
	assign fill_wr.index = lookup.fields.index;
	assign fill_wr.word  = fill_word;
	assign fill_wr.data  = bus_rdata;

	////////////////////////////////////////////////////////////
	// Sequencer state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= dcache_pkg::FILL_IDLE;
			word_cnt <= '0;
		end else if (beat) begin
			if (line_done) begin
				state    <= dcache_pkg::FILL_IDLE;
				word_cnt <= '0;
			end else begin
				state    <= dcache_pkg::FILL_RUN;
				word_cnt <= fill_word + 1'b1;
			end
		end else if (restart) begin
			state    <= dcache_pkg::FILL_IDLE;
			word_cnt <= '0;
		end
	end

	// The line address is only looked at while running.
	always_ff @(posedge clk) begin
		if (beat) begin
			fill_line <= cur_line;
		end
	end

	// An idle sequencer always waits at word 0.
	a_idle_at_word0: assert property (
		@(posedge clk) disable iff (!rst_n)
		(state == dcache_pkg::FILL_IDLE) |-> (word_cnt == '0)
	) else $error("fill sequencer idle with a nonzero word count");

endmodule

//--- dcache_lookup.sv
// Tag and valid store
// Address split and hit compare.
module dcache_lookup (
	input  logic                  clk,
	input  logic                  rst_n,
	input  dcache_pkg::core_req_t req,
	input  logic                  line_done,
	output dcache_pkg::lookup_t   lookup
);

	dcache_pkg::addr_fields_t fields;

	// One valid bit per line, cleared by reset.
	logic [dcache_pkg::line_count-1:0] valid;

	// Tags need no reset since valid guards them.
	logic [dcache_pkg::tag_width-1:0] tags [dcache_pkg::line_count];

	logic tag_match;

	////////////////////////////////////////////////////////////
	// Address split and compare
	////////////////////////////////////////////////////////////

	assign fields = dcache_pkg::addr_fields_t'(req.addr);

	assign tag_match = (tags[fields.index] == fields.tag);

	assign lookup.fields = fields;
	assign lookup.hit    = valid[fields.index] && tag_match;

	////////////////////////////////////////////////////////////
	// Install on fill completion
	////////////////////////////////////////////////////////////

	// The last fill beat installs the line, so the next cycle hits.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (line_done) begin
			valid[fields.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (line_done) begin
			tags[fields.index] <= fields.tag;	// Replaces any previous tag here.
		end
	end

	// The core holds its read through the last beat, so the next cycle hits.
	a_done_then_hit: assert property (
		@(posedge clk) disable iff (!rst_n)
		line_done |=> lookup.hit
	) else $error("installed line does not hit in the next cycle");

endmodule

//--- dcache_pkg.sv
// Data cache shared definitions
package dcache_pkg;

	////////////////////////////////////////////////////////////
	// Geometry
	////////////////////////////////////////////////////////////

	localparam int line_count     = 16;	// 16 lines of 64 bytes.
	localparam int words_per_line = 16;
	localparam int tag_width      = 22;
	localparam int index_width    = 4;
	localparam int word_width     = 4;

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////

	// Address split: tag, line index, word in line, byte offset.
	typedef struct packed {
		logic [tag_width-1:0]   tag;
		logic [index_width-1:0] index;
		logic [word_width-1:0]  word;
		logic [1:0]             offset;
	} addr_fields_t;

	// Core request as seen by every stage.
	typedef struct packed {
		logic [31:0] addr;
		logic        rd;
		logic        wr;
		logic [31:0] wdata;
	} core_req_t;

	typedef struct packed {
		addr_fields_t fields;
		logic         hit;	// Valid line with matching tag.
	} lookup_t;

	typedef enum logic [0:0] {FILL_IDLE, FILL_RUN} fill_state_e;

	typedef enum logic [1:0] {BUS_IDLE, BUS_READ, BUS_WRITE} bus_op_e;

	typedef struct packed {
		bus_op_e     op;
		logic [31:0] addr;
		logic [31:0] wdata;
	} bus_cmd_t;

	// One word written into the data array during a line fill.
	typedef struct packed {
		logic                   en;
		logic [index_width-1:0] index;
		logic [word_width-1:0]  word;
		logic [31:0]            data;
	} fill_wr_t;

endpackage
